//--- Bender.yml
package:
  name: rsa_uart

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rsa_pkg.sv
      - hdl/avm_pkg.sv
      - hdl/rsa_mont.sv
      - hdl/rsa_core.sv
      - hdl/rsa_avm_wrapper.sv
      - hdl/rsa_uart_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verification/rsa_sva.sv
      - verification/rsa_checker.sv
      - verification/rsa_tb.sv

//--- flist.f
+incdir+hdl
hdl/rsa_pkg.sv
hdl/avm_pkg.sv
hdl/rsa_mont.sv
hdl/rsa_core.sv
hdl/rsa_avm_wrapper.sv
hdl/rsa_uart_top.sv
verification/rsa_sva.sv
verification/rsa_checker.sv
verification/rsa_tb.sv

//--- hdl/avm_pkg.sv
`default_nettype none

`include "rsa_cfg.svh"

package avm_pkg;

    typedef logic [`AVM_ADDR_W-1:0] avm_addr_t;
    typedef logic [`AVM_DATA_W-1:0] avm_data_t;

    // Status register bits of the serial port
    localparam int TX_OK_BIT = 6;
    localparam int RX_OK_BIT = 7;

    typedef enum logic [2:0] {
        POLL_RX,     // Status read, wait for RX_OK
        READ_RX,     // Read one byte from RX_BASE
        START_CORE,  // Start pulse to the core
        WAIT_CORE,   // Bus idle until finished
        POLL_TX,     // Status read, wait for TX_OK
        WRITE_TX     // Write one byte to TX_BASE
    } wrap_state_t;

endpackage

`default_nettype wire

//--- hdl/rsa_avm_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_avm_wrapper (
    input  wire                avm_clk,
    input  wire                avm_rst,
    output avm_pkg::avm_addr_t address,
    output logic               read,
    input  wire avm_pkg::avm_data_t readdata,
    output logic               write,
    output avm_pkg::avm_data_t writedata,
    input  wire                waitrequest,
    output logic               core_start,
    output rsa_pkg::operand_t  core_a,
    output rsa_pkg::operand_t  core_d,
    output rsa_pkg::operand_t  core_n,
    input  wire rsa_pkg::operand_t core_result,
    input  wire                core_finished
);
    import avm_pkg::*;
    import rsa_pkg::*;

    localparam int RX_BYTES = 3 * (`RSA_WIDTH / 8);  // n, d and a
    localparam int TX_BYTES = `RSA_WIDTH / 8 - 1;    // Top byte of the result is not sent

    wrap_state_t state;
    logic [6:0]  byte_cnt;
    operand_t    n_r;
    operand_t    d_r;
    operand_t    a_r;
    operand_t    out_r;
    logic        rx_done;   // Byte read from RX_BASE completes
    logic        tx_done;   // Byte write to TX_BASE completes

    assign rx_done = (state == READ_RX) && !waitrequest;
    assign tx_done = (state == WRITE_TX) && !waitrequest;

    assign core_start = (state == START_CORE);
    assign core_a     = a_r;
    assign core_d     = d_r;
    assign core_n     = n_r;
    assign writedata  = {{(`AVM_DATA_W-8){1'b0}}, out_r[`RSA_WIDTH-9 -: 8]};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= POLL_RX;
            address  <= `STATUS_BASE;
            read     <= 1'b1;
            write    <= 1'b0;
            byte_cnt <= '0;
        end else begin
            case (state)
                POLL_RX: begin
                    if (!waitrequest && readdata[RX_OK_BIT]) begin
                        address <= `RX_BASE;
                        state   <= READ_RX;
                    end
                end
                READ_RX: begin
                    if (!waitrequest) begin
                        if (byte_cnt == RX_BYTES - 1) begin
                            byte_cnt <= '0;
                            read     <= 1'b0;
                            address  <= `STATUS_BASE;
                            state    <= START_CORE;
                        end else begin
                            byte_cnt <= byte_cnt + 7'd1;
                            address  <= `STATUS_BASE;
                            state    <= POLL_RX;
                        end
                    end
                end
                START_CORE: begin
                    state <= WAIT_CORE;
                end
                WAIT_CORE: begin
                    if (core_finished) begin
                        read    <= 1'b1;
                        address <= `STATUS_BASE;
                        state   <= POLL_TX;
                    end
                end
                POLL_TX: begin
                    if (!waitrequest && readdata[TX_OK_BIT]) begin
                        read    <= 1'b0;
                        write   <= 1'b1;
                        address <= `TX_BASE;
                        state   <= WRITE_TX;
                    end
                end
                WRITE_TX: begin
                    if (!waitrequest) begin
                        write   <= 1'b0;
                        read    <= 1'b1;
                        address <= `STATUS_BASE;
                        if (byte_cnt == TX_BYTES - 1) begin
                            byte_cnt <= '0;
                            state    <= POLL_RX;
                        end else begin
                            byte_cnt <= byte_cnt + 7'd1;
                            state    <= POLL_TX;
                        end
                    end
                end
                default: begin
                    state <= POLL_RX;
                end
            endcase
        end
    end

    // Bytes enter at a and move up through d into n
    always_ff @(posedge avm_clk) begin
        if (rx_done) begin
            {n_r, d_r, a_r} <= {n_r[`RSA_WIDTH-9:0], d_r, a_r, readdata[7:0]};
        end
        if (state == WAIT_CORE && core_finished) begin
            out_r <= core_result;
        end else if (tx_done) begin
            out_r <= out_r << 8;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rsa_cfg.svh
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// Operand width of the exponentiation datapath
`define RSA_WIDTH 256

// Avalon-MM master widths
`define AVM_ADDR_W 5
`define AVM_DATA_W 32

// Serial port register map, byte addresses
`define RX_BASE     5'd0
`define TX_BASE     5'd4
`define STATUS_BASE 5'd8

`endif

//--- hdl/rsa_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_core (
    input  wire               avm_clk,
    input  wire               avm_rst,
    input  wire               start,
    input  wire rsa_pkg::operand_t a,
    input  wire rsa_pkg::operand_t d,
    input  wire rsa_pkg::operand_t n,
    output rsa_pkg::operand_t result,
    output logic              finished
);
    import rsa_pkg::*;

    localparam int STEPS = `RSA_WIDTH;

    core_phase_t phase;
    logic [8:0]  cnt;
    logic        mont_go;   // Start for the multipliers, one cycle
    operand_t    pw;        // Running power of a, Montgomery form
    operand_t    acc_m;     // Accumulator, Montgomery form
    operand_t    d_r;
    operand_t    mul_y;
    operand_t    mul_p;
    operand_t    sq_p;
    logic        mul_done;
    logic        sq_done;
    logic        sq_start;

    // One doubling step of v modulo m, v below m
    function automatic operand_t dbl_mod(input operand_t v, input operand_t m);
        logic [`RSA_WIDTH:0] t;
        t = {v, 1'b0};
        if (t >= {1'b0, m}) begin
            t = t - {1'b0, m};
        end
        return t[`RSA_WIDTH-1:0];
    endfunction

    assign sq_start = mont_go && (phase == LOOP);
    assign mul_y    = (phase == DONE) ? operand_t'(1) : pw;  // Product with 1 leaves the domain

    rsa_mont mont_mul (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_go),
        .x       (acc_m),
        .y       (mul_y),
        .n       (n),
        .p       (mul_p),
        .done    (mul_done)
    );

    rsa_mont mont_sq (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (sq_start),
        .x       (pw),
        .y       (pw),
        .n       (n),
        .p       (sq_p),
        .done    (sq_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            phase    <= IDLE;
            cnt      <= '0;
            mont_go  <= 1'b0;
            finished <= 1'b0;
        end else begin
            mont_go  <= 1'b0;
            finished <= 1'b0;
            case (phase)
                IDLE: begin
                    if (start) begin
                        phase <= PRESCALE;
                        cnt   <= '0;
                    end
                end
                PRESCALE: begin
                    cnt <= cnt + 9'd1;
                    if (cnt == STEPS) begin  // 256 doublings plus this cycle
                        phase   <= LOOP;
                        cnt     <= '0;
                        mont_go <= 1'b1;
                    end
                end
                LOOP: begin
                    if (mul_done && sq_done) begin
                        cnt     <= cnt + 9'd1;
                        mont_go <= 1'b1;
                        if (cnt == STEPS - 1) begin
                            phase <= DONE;
                        end
                    end
                end
                DONE: begin
                    if (mul_done) begin
                        finished <= 1'b1;
                        phase    <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (phase)
            IDLE: begin
                if (start) begin
                    pw    <= a;
                    acc_m <= operand_t'(1);  // Becomes 2^256 mod n
                    d_r   <= d;
                end
            end
            PRESCALE: begin
                if (cnt < STEPS) begin
                    pw    <= dbl_mod(pw, n);
                    acc_m <= dbl_mod(acc_m, n);
                end
            end
            LOOP: begin
                if (mul_done && sq_done) begin
                    pw <= sq_p;
                    if (d_r[0]) begin
                        acc_m <= mul_p;
                    end
                    d_r <= d_r >> 1;
                end
            end
            DONE: begin
                if (mul_done) begin
                    result <= mul_p;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rsa_mont.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_mont (
    input  wire               avm_clk,
    input  wire               avm_rst,
    input  wire               start,
    input  wire rsa_pkg::operand_t x,
    input  wire rsa_pkg::operand_t y,
    input  wire rsa_pkg::operand_t n,
    output rsa_pkg::operand_t p,
    output logic              done
);
    import rsa_pkg::*;

    localparam int STEPS = `RSA_WIDTH;

    operand_t              x_r;
    operand_t              y_r;
    operand_t              n_r;
    logic [`RSA_WIDTH+1:0] acc;  // Stays below 2n between steps
    logic [`RSA_WIDTH+1:0] sum;
    logic [8:0]            cnt;
    logic                  busy;

    always_comb begin
        sum = acc + (x_r[0] ? {2'b00, y_r} : '0);
        if (sum[0]) begin
            sum = sum + {2'b00, n_r};  // Make even before halving
        end
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 9'd1;
                if (cnt == STEPS + 1) begin  // 256 steps, one subtract, then done
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            x_r <= x;
            y_r <= y;
            n_r <= n;
            acc <= '0;
        end else if (busy) begin
            if (cnt < STEPS) begin
                acc <= sum >> 1;
                x_r <= x_r >> 1;
            end else if (cnt == STEPS && acc >= {2'b00, n_r}) begin
                acc <= acc - {2'b00, n_r};
            end
        end
    end

    assign p = acc[`RSA_WIDTH-1:0];

endmodule

`default_nettype wire

//--- hdl/rsa_pkg.sv
`default_nettype none

`include "rsa_cfg.svh"

package rsa_pkg;

    // One modular operand or result
    typedef logic [`RSA_WIDTH-1:0] operand_t;

    // Phases of the exponentiation core
    typedef enum logic [1:0] {
        IDLE,      // Waiting for start
        PRESCALE,  // Operands into Montgomery domain
        LOOP,      // Square-and-multiply over d
        DONE       // Final product with 1
    } core_phase_t;

endpackage

`default_nettype wire

//--- hdl/rsa_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_uart_top (
    input  wire                avm_clk,
    input  wire                avm_rst,
    output avm_pkg::avm_addr_t address,
    output logic               read,
    input  wire avm_pkg::avm_data_t readdata,
    output logic               write,
    output avm_pkg::avm_data_t writedata,
    input  wire                waitrequest
);
    import rsa_pkg::*;

    logic     core_start;
    logic     core_finished;
    operand_t core_a;
    operand_t core_d;
    operand_t core_n;
    operand_t core_result;

    rsa_avm_wrapper u_wrapper (
        .avm_clk       (avm_clk),
        .avm_rst       (avm_rst),
        .address       (address),
        .read          (read),
        .readdata      (readdata),
        .write         (write),
        .writedata     (writedata),
        .waitrequest   (waitrequest),
        .core_start    (core_start),
        .core_a        (core_a),
        .core_d        (core_d),
        .core_n        (core_n),
        .core_result   (core_result),
        .core_finished (core_finished)
    );

    rsa_core u_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start),
        .a        (core_a),
        .d        (core_d),
        .n        (core_n),
        .result   (core_result),
        .finished (core_finished)
    );

endmodule

`default_nettype wire

//--- verification/rsa_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_checker (
    input wire                     avm_clk,
    input wire                     avm_rst,
    input wire avm_pkg::avm_addr_t address,
    input wire                     write,
    input wire avm_pkg::avm_data_t writedata,
    input wire                     waitrequest,
    input wire                     job_valid,
    input wire rsa_pkg::operand_t  job_n,
    input wire rsa_pkg::operand_t  job_d,
    input wire rsa_pkg::operand_t  job_a,
    output int                     tests_done,
    output int                     tests_bad,
    output int                     bus_errors
);
    import rsa_pkg::*;

    localparam int TX_BYTES = `RSA_WIDTH / 8 - 1;

    operand_t              exp_q[$];  // Expected results, oldest job first
    operand_t              exp_r;
    logic [8*TX_BYTES-1:0] got;
    int                    byte_cnt;

    // Plain square-and-multiply, products kept to 512 bits
    function automatic operand_t mod_exp(input operand_t a, input operand_t d,
                                         input operand_t n);
        logic [2*`RSA_WIDTH-1:0] nn;
        logic [2*`RSA_WIDTH-1:0] base;
        logic [2*`RSA_WIDTH-1:0] acc;
        int                      i;
        nn   = {{`RSA_WIDTH{1'b0}}, n};
        base = {{`RSA_WIDTH{1'b0}}, a} % nn;
        acc  = 1 % nn;
        for (i = 0; i < `RSA_WIDTH; i++) begin
            if (d[i]) begin
                acc = (acc * base) % nn;
            end
            base = (base * base) % nn;
        end
        return acc[`RSA_WIDTH-1:0];
    endfunction

    always @(posedge avm_clk) begin
        if (avm_rst) begin
            tests_done = 0;
            tests_bad  = 0;
            bus_errors = 0;
            byte_cnt   = 0;
            got        = '0;
        end else begin
            if (job_valid) begin
                exp_q.push_back(mod_exp(job_a, job_d, job_n));
            end
            if (write && !waitrequest) begin
                if (address != `TX_BASE) begin
                    $display("error: address on write got 0x%h expected 0x%h",
                             address, `TX_BASE);
                    bus_errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("write to the transmit register with no job outstanding");
                    bus_errors++;
                end else begin
                    got = {got[8*TX_BYTES-9:0], writedata[7:0]};  // MSB arrives first
                    byte_cnt++;
                    if (byte_cnt == TX_BYTES) begin
                        exp_r = exp_q.pop_front();
                        tests_done++;
                        if (got !== exp_r[8*TX_BYTES-1:0]) begin
                            $display("error: writedata bytes of job %0d got 0x%h expected 0x%h",
                                     tests_done, got, exp_r[8*TX_BYTES-1:0]);
                            tests_bad++;
                            $display("job %0d: mismatch", tests_done);
                        end else begin
                            $display("job %0d: result ok", tests_done);
                        end
                        byte_cnt = 0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/rsa_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_sva (
    input wire                     avm_clk,
    input wire                     avm_rst,
    input wire avm_pkg::avm_addr_t address,
    input wire                     read,
    input wire                     write,
    input wire avm_pkg::avm_data_t writedata,
    input wire                     waitrequest,
    input wire                     core_start,
    input wire                     core_finished
);
    int fail_count = 0;  // Read by the testbench at the end of the run

    // Request, address and data frozen while the slave stalls
    a_hold_on_wait: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writedata))
    else begin
        $error("bus request changed while waitrequest was high");
        fail_count++;
    end

    a_reset_values: assert property (@(posedge avm_clk)
        avm_rst |-> read && !write && address == `STATUS_BASE)
    else begin
        $error("bus outputs differ from their reset values during reset");
        fail_count++;
    end

    a_one_request: assert property (@(posedge avm_clk) !(read && write))
    else begin
        $error("read and write asserted together");
        fail_count++;
    end

    // Bus stays quiet around the core run
    a_idle_at_start: assert property (@(posedge avm_clk) disable iff (avm_rst)
        core_start |-> !read && !write)
    else begin
        $error("bus busy while the core is started");
        fail_count++;
    end

    a_idle_at_finish: assert property (@(posedge avm_clk) disable iff (avm_rst)
        core_finished |-> !read && !write)
    else begin
        $error("bus busy when the core finished");
        fail_count++;
    end

endmodule

bind rsa_uart_top rsa_sva u_sva (
    .avm_clk       (avm_clk),
    .avm_rst       (avm_rst),
    .address       (address),
    .read          (read),
    .write         (write),
    .writedata     (writedata),
    .waitrequest   (waitrequest),
    .core_start    (core_start),
    .core_finished (core_finished)
);

`default_nettype wire

//--- verification/rsa_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_tb;
    import avm_pkg::*;
    import rsa_pkg::*;

    localparam int NUM_JOBS     = 6;
    localparam int JOB_CYCLES   = 70000;  // Core run is about 67k cycles
    localparam int CYCLE_LIMIT  = NUM_JOBS * JOB_CYCLES;
    localparam int STALL_CYCLES = 300;
    localparam int RX_BYTES     = 3 * (`RSA_WIDTH / 8);

    logic      avm_clk;
    logic      avm_rst;
    avm_addr_t address;
    logic      read;
    avm_data_t readdata;
    logic      write;
    avm_data_t writedata;
    logic      waitrequest;
    logic      job_valid;
    operand_t  job_n;
    operand_t  job_d;
    operand_t  job_a;
    int        tests_done;
    int        tests_bad;
    int        bus_errors;

    logic [15:0] lfsr;
    logic [7:0]  rx_q[$];  // Bytes waiting in the serial port
    int          cycles = 0;
    int          tb_errors = 0;

    rsa_uart_top UUT (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (address),
        .read        (read),
        .readdata    (readdata),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest)
    );

    rsa_checker u_checker (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (address),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .job_valid   (job_valid),
        .job_n       (job_n),
        .job_d       (job_d),
        .job_a       (job_a),
        .tests_done  (tests_done),
        .tests_bad   (tests_bad),
        .bus_errors  (bus_errors)
    );

    always #2 avm_clk = ~avm_clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic next_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // Serial port registers answer only in the completing cycle
    always @(negedge avm_clk) begin
        waitrequest = next_bit();
        readdata    = '0;
        if (read && !waitrequest) begin
            if (address == `STATUS_BASE) begin
                readdata[RX_OK_BIT] = (rx_q.size() != 0);
                readdata[TX_OK_BIT] = next_bit();
            end else if (address == `RX_BASE) begin
                if (rx_q.size() == 0) begin
                    $display("read from the receive register while no byte was waiting");
                    tb_errors++;
                end else begin
                    readdata[7:0] = rx_q.pop_front();
                end
            end
        end
    end

    always @(posedge avm_clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d jobs done",
                     cycles, tests_done, NUM_JOBS);
            $display("tests failed");
            $finish;
        end
    end

    task automatic make_key(output operand_t n, output operand_t d, output operand_t a);
        int i;
        @(posedge avm_clk);
        for (i = 0; i < `RSA_WIDTH; i++) n[i] = next_bit();
        for (i = 0; i < `RSA_WIDTH; i++) d[i] = next_bit();
        for (i = 0; i < `RSA_WIDTH; i++) a[i] = next_bit();
        n[`RSA_WIDTH-1] = 1'b1;
        n[0]            = 1'b1;  // Odd modulus
        a[`RSA_WIDTH-1] = 1'b0;  // Keeps a below n
    endtask

    task automatic announce_job(input operand_t n, input operand_t d, input operand_t a);
        @(negedge avm_clk);
        job_n     = n;
        job_d     = d;
        job_a     = a;
        job_valid = 1'b1;
        @(negedge avm_clk);
        job_valid = 1'b0;
    endtask

    // Byte stream holds n then d then a in MSB-first order
    task automatic push_bytes(input operand_t n, input operand_t d, input operand_t a,
                              input int first, input int count);
        logic [3*`RSA_WIDTH-1:0] stream;
        int k;
        stream = {n, d, a};
        @(posedge avm_clk);
        for (k = first; k < first + count; k++) begin
            rx_q.push_back(stream[3*`RSA_WIDTH-1-8*k -: 8]);
        end
    endtask

    task automatic watch_idle(input string label, input int ncycles);
        int i;
        for (i = 0; i < ncycles; i++) begin
            if (write !== 1'b0 || read !== 1'b1 || address !== `STATUS_BASE) begin
                $display("error: %s write got 0x%h expected 0x0, read got 0x%h expected 0x1",
                         label, write, read);
                $display("error: %s address got 0x%h expected 0x%h",
                         label, address, `STATUS_BASE);
                tb_errors++;
                return;
            end
            @(negedge avm_clk);
        end
        $display("idle check %s: ok", label);
    endtask

    task automatic wait_results(input int target);
        while (tests_done < target) @(negedge avm_clk);
    endtask

    initial begin
        operand_t n;
        operand_t d;
        operand_t a;
        operand_t kn[3];
        operand_t kd[3];
        operand_t ka[3];
        int       j;
        avm_clk     = 1'b0;
        avm_rst     = 1'b0;
        readdata    = '0;
        waitrequest = 1'b0;
        job_valid   = 1'b0;
        job_n       = '0;
        job_d       = '0;
        job_a       = '0;
        lfsr        = 16'd70;
        #1;
        avm_rst = 1'b1;  // Asynchronous reset edge ahead of the first clock edge
        repeat (16) @(negedge avm_clk);
        avm_rst = 1'b0;
        watch_idle("after reset", STALL_CYCLES);

        // Random job split by a stall with an empty receive queue
        make_key(n, d, a);
        announce_job(n, d, a);
        push_bytes(n, d, a, 0, 40);
        while (rx_q.size() != 0) @(posedge avm_clk);
        @(negedge avm_clk);
        watch_idle("partial job", STALL_CYCLES);
        push_bytes(n, d, a, 40, RX_BYTES - 40);
        wait_results(1);

        make_key(n, d, a);
        d = operand_t'(1);
        announce_job(n, d, a);
        push_bytes(n, d, a, 0, RX_BYTES);
        wait_results(2);

        make_key(n, d, a);
        d = '0;
        announce_job(n, d, a);
        push_bytes(n, d, a, 0, RX_BYTES);
        wait_results(3);

        // Three keys queued back to back
        for (j = 0; j < 3; j++) begin
            make_key(kn[j], kd[j], ka[j]);
            announce_job(kn[j], kd[j], ka[j]);
            push_bytes(kn[j], kd[j], ka[j], 0, RX_BYTES);
        end
        wait_results(NUM_JOBS);
        watch_idle("after last job", 100);

        $display("%0d jobs checked, %0d mismatches, %0d other errors, %0d assertion failures",
                 tests_done, tests_bad, tb_errors + bus_errors, UUT.u_sva.fail_count);
        if (tests_done == NUM_JOBS && tests_bad == 0 && tb_errors == 0 && bus_errors == 0
                && UUT.u_sva.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
